//--- compile.f
+incdir+common
common/hbus_native_pkg.sv
common/hbus_cmd_pkg.sv
hyperbus_fifo/hbus_sync_fifo.sv
hyperbus_fifo/hbus_user_ctrl.sv
hyperbus_fifo/hbus_xfer_ctrl.sv
hyperbus_fifo/hyperbus_fifo.sv
test/tb_clk_gen.sv
test/hbus_mem_model.sv
test/tb_hyperbus_fifo.sv

//--- run_sim.sh
#!/bin/sh
# Build the HyperBus bridge testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
  --top-module tb_hyperbus_fifo -Mdir "$BUILD_DIR" -f compile.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/Vtb_hyperbus_fifo" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "sim passed" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1

//--- test/tb_hyperbus_fifo.sv
// HyperBus bridge testbench: random writes, read-back and unwritten reads under assertions
`default_nettype none

`include "hbus_bridge_config.svh"

module tb_hyperbus_fifo import hbus_native_pkg::*, hbus_cmd_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned NUM_WRITES  = 20;
  localparam int unsigned NUM_BLANK   = 10;
  localparam int unsigned NUM_REQS    = 2 * NUM_WRITES + NUM_BLANK;
  localparam int unsigned CYCLE_BOUND = 40;
  localparam int unsigned BEATS       = `HBUS_BEATS;
  localparam int unsigned BEAT_W      = `HBUS_DATA_W;

  logic       clk;
  logic       hbus_rst;
  logic       rrq;
  logic       wrq;
  hbus_addr_t adr;
  user_word_t tx_dat;
  logic       tx_ready;
  user_word_t rx_dat;
  logic       rx_valid;
  hbus_addr_t hbus_adr;
  hbus_beat_t hbus_dat_to_dut;
  hbus_beat_t hbus_dat_from_dut;
  logic       hbus_rrq;
  logic       hbus_wrq;
  logic       hbus_ready;
  logic       hbus_valid;
  user_word_t mem_stored;

  // Request in flight
  string      test_name;
  hbus_addr_t exp_adr;
  user_word_t exp_wdata;
  user_word_t exp_rdata;

  // Last written word per address
  user_word_t sb [hbus_addr_t];
  hbus_addr_t written [$];

  int unsigned wr_beats;
  int unsigned rd_beats;
  logic        wr_pending;
  logic        rd_pending;

  tb_clk_gen u_clk_gen (
    .clk_o      (clk),
    .hbus_rst_o (hbus_rst)
  );

  hbus_mem_model u_mem (
    .clk      (clk),
    .hbus_rst (hbus_rst),
    .adr_i    (hbus_adr),
    .wdat_i   (hbus_dat_from_dut),
    .rrq_i    (hbus_rrq),
    .wrq_i    (hbus_wrq),
    .rdat_o   (hbus_dat_to_dut),
    .ready_o  (hbus_ready),
    .valid_o  (hbus_valid),
    .stored_o (mem_stored)
  );

  hyperbus_fifo u_dut (
    .clk          (clk),
    .hbus_rst     (hbus_rst),
    .rrq_i        (rrq),
    .wrq_i        (wrq),
    .adr_i        (adr),
    .tx_dat_i     (tx_dat),
    .tx_ready_o   (tx_ready),
    .rx_dat_o     (rx_dat),
    .rx_valid_o   (rx_valid),
    .hbus_adr_o   (hbus_adr),
    .hbus_dat_i   (hbus_dat_to_dut),
    .hbus_dat_o   (hbus_dat_from_dut),
    .hbus_rrq_o   (hbus_rrq),
    .hbus_wrq_o   (hbus_wrq),
    .hbus_ready_i (hbus_ready),
    .hbus_valid_i (hbus_valid)
  );

  // Expected bus beat, upper half goes first
  function automatic hbus_beat_t upper_first_beat(input user_word_t word, input int unsigned idx);
    return hbus_beat_t'(word >> (BEAT_W * (BEATS - 1 - idx)));
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("sim failed");
    $fatal(1, "Stopped at the first failing check");
  endtask

  // One request, held for a cycle, then wait for its completion pulse
  task automatic run_request(input string name, input logic is_read, input hbus_addr_t a,
                             input user_word_t wdata, input user_word_t rdata_exp);
    @(posedge clk);
    rrq       <= is_read;
    wrq       <= !is_read;
    adr       <= a;
    tx_dat    <= wdata;
    test_name <= name;
    exp_adr   <= a;
    exp_wdata <= wdata;
    exp_rdata <= rdata_exp;
    @(posedge clk);
    rrq <= 1'b0;
    wrq <= 1'b0;
    @(posedge clk);
    while (!(tx_ready || rx_valid)) begin
      @(posedge clk);
    end
  endtask

  // Beat counters and pending flags of the current request
  always @(posedge clk or posedge hbus_rst) begin
    if (hbus_rst) begin
      wr_beats   <= 0;
      rd_beats   <= 0;
      wr_pending <= 1'b0;
      rd_pending <= 1'b0;
    end else if (rrq || wrq) begin
      wr_beats   <= 0;
      rd_beats   <= 0;
      rd_pending <= rrq;
      wr_pending <= !rrq && wrq;
    end else begin
      if (hbus_wrq && hbus_ready) begin
        wr_beats <= wr_beats + 1;
      end
      if (hbus_rrq && hbus_valid) begin
        rd_beats <= rd_beats + 1;
      end
      if (tx_ready) begin
        wr_pending <= 1'b0;
      end
      if (rx_valid) begin
        rd_pending <= 1'b0;
      end
    end
  end

  a_reset_quiet: assert property (@(posedge clk)
    (hbus_rst || $past(hbus_rst)) |-> !(hbus_rrq || hbus_wrq || rx_valid || tx_ready))
    else abort_run("Bus request or user pulse was high during or right after reset");

  a_req_exclusive: assert property (@(posedge clk) disable iff (hbus_rst)
    !(hbus_rrq && hbus_wrq) && !(hbus_rrq && wr_pending) && !(hbus_wrq && rd_pending))
    else abort_run("Bus read and write requests overlapped");

  a_bus_adr: assert property (@(posedge clk) disable iff (hbus_rst)
    (hbus_rrq || hbus_wrq) |-> hbus_adr == exp_adr)
    else abort_run($sformatf("Error %s bus address: expected %h actual %h",
                             test_name, $sampled(exp_adr), $sampled(hbus_adr)));

  a_wr_beat: assert property (@(posedge clk) disable iff (hbus_rst)
    (hbus_wrq && hbus_ready) |-> hbus_dat_from_dut == upper_first_beat(exp_wdata, wr_beats))
    else abort_run($sformatf("Error %s write beat %0d: expected %h actual %h", test_name,
                             $sampled(wr_beats),
                             upper_first_beat($sampled(exp_wdata), $sampled(wr_beats)),
                             $sampled(hbus_dat_from_dut)));

  a_tx_ready_once: assert property (@(posedge clk) disable iff (hbus_rst)
    tx_ready |-> wr_pending)
    else abort_run("Write acknowledge pulse came with no write pending");

  a_wr_count: assert property (@(posedge clk) disable iff (hbus_rst)
    tx_ready |-> wr_beats == BEATS)
    else abort_run($sformatf("Error %s write beat count: expected %0d actual %0d",
                             test_name, BEATS, $sampled(wr_beats)));

  a_wr_stored: assert property (@(posedge clk) disable iff (hbus_rst)
    tx_ready |-> mem_stored == exp_wdata)
    else abort_run($sformatf("Error %s stored word: expected %h actual %h",
                             test_name, $sampled(exp_wdata), $sampled(mem_stored)));

  a_rx_valid_once: assert property (@(posedge clk) disable iff (hbus_rst)
    rx_valid |-> rd_pending)
    else abort_run("Read data pulse came with no read pending");

  a_rd_count: assert property (@(posedge clk) disable iff (hbus_rst)
    rx_valid |-> rd_beats == BEATS)
    else abort_run($sformatf("Error %s read beat count: expected %0d actual %0d",
                             test_name, BEATS, $sampled(rd_beats)));

  a_rd_data: assert property (@(posedge clk) disable iff (hbus_rst)
    rx_valid |-> rx_dat == exp_rdata)
    else abort_run($sformatf("Error %s read data: expected %h actual %h",
                             test_name, $sampled(exp_rdata), $sampled(rx_dat)));

  initial begin
    hbus_addr_t a;
    user_word_t d;
    void'($urandom(27628));
    rrq       = 1'b0;
    wrq       = 1'b0;
    adr       = '0;
    tx_dat    = '0;
    test_name = "reset";
    exp_adr   = '0;
    exp_wdata = '0;
    exp_rdata = '0;
    @(negedge hbus_rst);
    for (int i = 0; i < NUM_WRITES; i++) begin
      a = $urandom;
      d = $urandom;
      if (!sb.exists(a)) begin
        written.push_back(a);
      end
      sb[a] = d;
      run_request("write", 1'b0, a, d, '0);
    end
    foreach (written[k]) begin
      run_request("read_back", 1'b1, written[k], '0, sb[written[k]]);
    end
    // Fresh addresses come back as zero
    for (int i = 0; i < NUM_BLANK; i++) begin
      do begin
        a = $urandom;
      end while (sb.exists(a));
      run_request("read_blank", 1'b1, a, '0, '0);
    end
    repeat (2) @(posedge clk);
    $display("sim passed");
    $finish;
  end

  initial begin
    repeat (NUM_REQS * CYCLE_BOUND + 8) @(posedge clk);
    abort_run("Timeout: the requests did not all complete within the cycle bound");
  end

endmodule : tb_hyperbus_fifo

`default_nettype wire

//--- test/hbus_mem_model.sv
// HyperBus device model: word store with random ready and valid gaps per beat
`default_nettype none

`include "hbus_bridge_config.svh"

module hbus_mem_model import hbus_native_pkg::*; (
  input  wire logic                         clk,
  input  wire logic                         hbus_rst,
  input  wire hbus_addr_t                   adr_i,
  input  wire hbus_beat_t                   wdat_i,
  input  wire logic                         rrq_i,
  input  wire logic                         wrq_i,
  output hbus_beat_t                        rdat_o,
  output logic                              ready_o,
  output logic                              valid_o,
  output logic [`HBUS_FIFO_DATA_W-1:0]      stored_o
);

  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned WORD_W = `HBUS_FIFO_DATA_W;
  localparam int unsigned BEAT_W = `HBUS_DATA_W;
  localparam int unsigned BEATS  = `HBUS_BEATS;

  logic [WORD_W-1:0] store [hbus_addr_t];
  logic [WORD_W-1:0] word_q = '0;
  logic [WORD_W-1:0] next_word;
  logic [WORD_W-1:0] stored_q = '0;
  hbus_beat_t        rdat_q = '0;
  logic              ready_q = 1'b0;
  logic              valid_q = 1'b0;
  int unsigned       gap_q = 1;
  int unsigned       beat_q = 0;

  assign rdat_o   = rdat_q;
  assign ready_o  = ready_q;
  assign valid_o  = valid_q;
  assign stored_o = stored_q;

  // Unwritten locations read as zero
  function automatic logic [WORD_W-1:0] read_word(input hbus_addr_t adr);
    if (store.exists(adr)) begin
      return store[adr];
    end
    return '0;
  endfunction

  // Beat idx of a word, upper half is beat 0
  function automatic hbus_beat_t beat_of(input logic [WORD_W-1:0] word, input int unsigned idx);
    return hbus_beat_t'(word >> (BEAT_W * (BEATS - 1 - idx)));
  endfunction

  always @(posedge clk or posedge hbus_rst) begin
    if (hbus_rst) begin
      ready_q  <= 1'b0;
      valid_q  <= 1'b0;
      rdat_q   <= '0;
      word_q   <= '0;
      stored_q <= '0;
      gap_q    <= 1;
      beat_q   <= 0;
    end else if (!rrq_i && !wrq_i) begin
      ready_q <= 1'b0;
      valid_q <= 1'b0;
      beat_q  <= 0;
      gap_q   <= 1 + ($urandom % 3);
    end else if ((wrq_i && ready_q) || (rrq_i && valid_q)) begin
      // Beat taken this cycle
      if (wrq_i) begin
        next_word = {word_q[WORD_W-BEAT_W-1:0], wdat_i};
        word_q <= next_word;
        if (beat_q == BEATS - 1) begin
          store[adr_i] = next_word;
          stored_q <= next_word;
        end
      end
      ready_q <= 1'b0;
      valid_q <= 1'b0;
      beat_q  <= beat_q + 1;
      gap_q   <= 1 + ($urandom % 3);
    end else if (gap_q > 1) begin
      gap_q <= gap_q - 1;
    end else if (wrq_i) begin
      ready_q <= 1'b1;
    end else begin
      valid_q <= 1'b1;
      rdat_q  <= beat_of(read_word(adr_i), beat_q);
    end
  end

endmodule : hbus_mem_model

`default_nettype wire

//--- test/tb_clk_gen.sv
// Testbench clock and reset source: 20 ns clock with reset held for two cycles
`default_nettype none

module tb_clk_gen (
  output logic clk_o,
  output logic hbus_rst_o
);

  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk_o = 1'b0;
    forever #10 clk_o = ~clk_o;
  end

  // Reset rises just after time zero so the async reset sees a clean edge
  initial begin
    hbus_rst_o = 1'b0;
    #1 hbus_rst_o = 1'b1;
    repeat (2) @(posedge clk_o);
    hbus_rst_o <= 1'b0;
  end

endmodule : tb_clk_gen

`default_nettype wire

//--- hyperbus_fifo/hyperbus_fifo.sv
// HyperBus bridge top: user and transfer controllers joined by four queues
`default_nettype none

module hyperbus_fifo import hbus_native_pkg::*, hbus_cmd_pkg::*; (
  input  wire logic       clk,
  input  wire logic       hbus_rst,

  // User port
  input  wire logic       rrq_i,
  input  wire logic       wrq_i,
  input  wire hbus_addr_t adr_i,
  input  wire user_word_t tx_dat_i,
  output logic            tx_ready_o,
  output user_word_t      rx_dat_o,
  output logic            rx_valid_o,

  // Memory bus
  output hbus_addr_t      hbus_adr_o,
  input  wire hbus_beat_t hbus_dat_i,
  output hbus_beat_t      hbus_dat_o,
  output logic            hbus_rrq_o,
  output logic            hbus_wrq_o,
  input  wire logic       hbus_ready_i,
  input  wire logic       hbus_valid_i
);

  // Command queue
  logic       cmd_winc;
  hbus_cmd_t  cmd_wdata;
  logic       cmd_rinc;
  hbus_cmd_t  cmd_rdata;
  logic       cmd_rempty;

  // Transmit queue
  logic       tx_winc;
  user_word_t tx_wdata;
  logic       tx_rinc;
  user_word_t tx_rdata;
  logic       tx_rempty;

  // Receive queue
  logic       rx_winc;
  user_word_t rx_wdata;
  logic       rx_rinc;
  user_word_t rx_rdata;
  logic       rx_rempty;

  // Acknowledge queue, only its fill level matters
  logic       ack_winc;
  logic       ack_rinc;
  logic       ack_rempty;

  hbus_user_ctrl u_user_ctrl (
    .clk          (clk),
    .hbus_rst     (hbus_rst),
    .rrq_i        (rrq_i),
    .wrq_i        (wrq_i),
    .adr_i        (adr_i),
    .tx_dat_i     (tx_dat_i),
    .cmd_winc_o   (cmd_winc),
    .cmd_wdata_o  (cmd_wdata),
    .tx_winc_o    (tx_winc),
    .tx_wdata_o   (tx_wdata),
    .rx_rempty_i  (rx_rempty),
    .rx_rdata_i   (rx_rdata),
    .rx_rinc_o    (rx_rinc),
    .ack_rempty_i (ack_rempty),
    .ack_rinc_o   (ack_rinc),
    .rx_dat_o     (rx_dat_o),
    .rx_valid_o   (rx_valid_o),
    .tx_ready_o   (tx_ready_o)
  );

  hbus_xfer_ctrl u_xfer_ctrl (
    .clk          (clk),
    .hbus_rst     (hbus_rst),
    .cmd_rempty_i (cmd_rempty),
    .cmd_rdata_i  (cmd_rdata),
    .cmd_rinc_o   (cmd_rinc),
    .tx_rempty_i  (tx_rempty),
    .tx_rdata_i   (tx_rdata),
    .tx_rinc_o    (tx_rinc),
    .rx_winc_o    (rx_winc),
    .rx_wdata_o   (rx_wdata),
    .ack_winc_o   (ack_winc),
    .hbus_adr_o   (hbus_adr_o),
    .hbus_dat_i   (hbus_dat_i),
    .hbus_dat_o   (hbus_dat_o),
    .hbus_rrq_o   (hbus_rrq_o),
    .hbus_wrq_o   (hbus_wrq_o),
    .hbus_ready_i (hbus_ready_i),
    .hbus_valid_i (hbus_valid_i)
  );

  // A single outstanding request never fills a queue, full flags stay open
  hbus_sync_fifo #(.DATA_W($bits(hbus_cmd_t))) u_cmd_fifo (
    .clk      (clk),
    .hbus_rst (hbus_rst),
    .winc_i   (cmd_winc),
    .wdata_i  (cmd_wdata),
    .wfull_o  (),
    .rinc_i   (cmd_rinc),
    .rdata_o  (cmd_rdata),
    .rempty_o (cmd_rempty)
  );

  hbus_sync_fifo #(.DATA_W($bits(user_word_t))) u_tx_fifo (
    .clk      (clk),
    .hbus_rst (hbus_rst),
    .winc_i   (tx_winc),
    .wdata_i  (tx_wdata),
    .wfull_o  (),
    .rinc_i   (tx_rinc),
    .rdata_o  (tx_rdata),
    .rempty_o (tx_rempty)
  );

  hbus_sync_fifo #(.DATA_W($bits(user_word_t))) u_rx_fifo (
    .clk      (clk),
    .hbus_rst (hbus_rst),
    .winc_i   (rx_winc),
    .wdata_i  (rx_wdata),
    .wfull_o  (),
    .rinc_i   (rx_rinc),
    .rdata_o  (rx_rdata),
    .rempty_o (rx_rempty)
  );

  hbus_sync_fifo #(.DATA_W(1)) u_ack_fifo (
    .clk      (clk),
    .hbus_rst (hbus_rst),
    .winc_i   (ack_winc),
    .wdata_i  (1'b1),
    .wfull_o  (),
    .rinc_i   (ack_rinc),
    .rdata_o  (),
    .rempty_o (ack_rempty)
  );

endmodule : hyperbus_fifo

`default_nettype wire

//--- hyperbus_fifo/hbus_xfer_ctrl.sv
// HyperBus transfer controller: splits queued words into bus beats and assembles reads
`default_nettype none

`include "hbus_bridge_config.svh"

module hbus_xfer_ctrl import hbus_native_pkg::*, hbus_cmd_pkg::*; (
  input  wire logic       clk,
  input  wire logic       hbus_rst,
  input  wire logic       cmd_rempty_i,
  input  wire hbus_cmd_t  cmd_rdata_i,
  output logic            cmd_rinc_o,
  input  wire logic       tx_rempty_i,
  input  wire user_word_t tx_rdata_i,
  output logic            tx_rinc_o,
  output logic            rx_winc_o,
  output user_word_t      rx_wdata_o,
  output logic            ack_winc_o,
  output hbus_addr_t      hbus_adr_o,
  input  wire hbus_beat_t hbus_dat_i,
  output hbus_beat_t      hbus_dat_o,
  output logic            hbus_rrq_o,
  output logic            hbus_wrq_o,
  input  wire logic       hbus_ready_i,
  input  wire logic       hbus_valid_i
);

  localparam int unsigned WORD_W = `HBUS_FIFO_DATA_W;
  localparam int unsigned BEAT_W = `HBUS_DATA_W;

  xfer_state_e    state_q;
  hbus_beat_cnt_t count_q;

  // One shift register serves both directions
  user_word_t shift_q;

  logic start;
  logic beat_rd;
  logic beat_wr;

  // A write also needs its data word at the transmit queue head
  assign start = (state_q == XFER_IDLE) && !cmd_rempty_i &&
                 (cmd_rdata_i.is_read || !tx_rempty_i);

  assign beat_rd = hbus_rrq_o && hbus_valid_i;
  assign beat_wr = hbus_wrq_o && hbus_ready_i;

  // Upper beat goes out first
  assign hbus_dat_o = shift_q[WORD_W-1 -: BEAT_W];
  assign rx_wdata_o = shift_q;

  always_ff @(posedge clk or posedge hbus_rst) begin
    if (hbus_rst) begin
      state_q    <= XFER_IDLE;
      count_q    <= '0;
      hbus_rrq_o <= 1'b0;
      hbus_wrq_o <= 1'b0;
      cmd_rinc_o <= 1'b0;
      tx_rinc_o  <= 1'b0;
      rx_winc_o  <= 1'b0;
      ack_winc_o <= 1'b0;
    end else begin
      cmd_rinc_o <= 1'b0;
      tx_rinc_o  <= 1'b0;
      rx_winc_o  <= 1'b0;
      ack_winc_o <= 1'b0;

      case (state_q)
        XFER_IDLE: begin
          if (start) begin
            cmd_rinc_o <= 1'b1;
            count_q    <= hbus_beat_cnt_t'(`HBUS_BEATS);
            if (cmd_rdata_i.is_read) begin
              hbus_rrq_o <= 1'b1;
              state_q    <= XFER_READ;
            end else begin
              hbus_wrq_o <= 1'b1;
              state_q    <= XFER_WRITE;
            end
          end
        end
        XFER_READ: begin
          if (count_q == '0) begin
            // Word is complete, hand it to the user side
            rx_winc_o <= 1'b1;
            state_q   <= XFER_IDLE;
          end else if (beat_rd) begin
            count_q <= count_q - 1'b1;
            if (count_q == hbus_beat_cnt_t'(1)) begin
              hbus_rrq_o <= 1'b0;
            end
          end
        end
        XFER_WRITE: begin
          if (count_q == '0) begin
            // Retire the data word and acknowledge
            tx_rinc_o  <= 1'b1;
            ack_winc_o <= 1'b1;
            state_q    <= XFER_IDLE;
          end else if (beat_wr) begin
            count_q <= count_q - 1'b1;
            if (count_q == hbus_beat_cnt_t'(1)) begin
              hbus_wrq_o <= 1'b0;
            end
          end
        end
        default: state_q <= XFER_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      hbus_adr_o <= cmd_rdata_i.addr;
      shift_q    <= cmd_rdata_i.is_read ? '0 : tx_rdata_i;
    end else if (beat_rd) begin
      // Read beats enter at the bottom
      shift_q <= {shift_q[WORD_W-BEAT_W-1:0], hbus_dat_i};
    end else if (beat_wr) begin
      shift_q <= {shift_q[WORD_W-BEAT_W-1:0], {BEAT_W{1'b0}}};
    end
  end

endmodule : hbus_xfer_ctrl

`default_nettype wire

//--- hyperbus_fifo/hbus_user_ctrl.sv
// HyperBus user controller: queues requests and returns read words and write acknowledges
`default_nettype none

module hbus_user_ctrl import hbus_native_pkg::*, hbus_cmd_pkg::*; (
  input  wire logic       clk,
  input  wire logic       hbus_rst,
  input  wire logic       rrq_i,
  input  wire logic       wrq_i,
  input  wire hbus_addr_t adr_i,
  input  wire user_word_t tx_dat_i,
  output logic            cmd_winc_o,
  output hbus_cmd_t       cmd_wdata_o,
  output logic            tx_winc_o,
  output user_word_t      tx_wdata_o,
  input  wire logic       rx_rempty_i,
  input  wire user_word_t rx_rdata_i,
  output logic            rx_rinc_o,
  input  wire logic       ack_rempty_i,
  output logic            ack_rinc_o,
  output user_word_t      rx_dat_o,
  output logic            rx_valid_o,
  output logic            tx_ready_o
);

  user_state_e state_q;

  always_ff @(posedge clk or posedge hbus_rst) begin
    if (hbus_rst) begin
      state_q    <= USER_IDLE;
      cmd_winc_o <= 1'b0;
      tx_winc_o  <= 1'b0;
      rx_rinc_o  <= 1'b0;
      ack_rinc_o <= 1'b0;
      rx_valid_o <= 1'b0;
      tx_ready_o <= 1'b0;
    end else begin
      // Strobes and user pulses last one cycle
      cmd_winc_o <= 1'b0;
      tx_winc_o  <= 1'b0;
      rx_rinc_o  <= 1'b0;
      ack_rinc_o <= 1'b0;
      rx_valid_o <= 1'b0;
      tx_ready_o <= 1'b0;

      case (state_q)
        USER_IDLE: begin
          // Read wins when both requests are up
          if (rrq_i) begin
            cmd_winc_o <= 1'b1;
            state_q    <= USER_WAIT_READ;
          end else if (wrq_i) begin
            cmd_winc_o <= 1'b1;
            tx_winc_o  <= 1'b1;
            state_q    <= USER_WAIT_WRITE;
          end
        end
        USER_WAIT_READ: begin
          if (!rx_rempty_i) begin
            rx_rinc_o  <= 1'b1;
            rx_valid_o <= 1'b1;
            state_q    <= USER_IDLE;
          end
        end
        USER_WAIT_WRITE: begin
          if (!ack_rempty_i) begin
            ack_rinc_o <= 1'b1;
            tx_ready_o <= 1'b1;
            state_q    <= USER_IDLE;
          end
        end
        default: state_q <= USER_IDLE;
      endcase
    end
  end

  // Command, write data and read word registers
  always_ff @(posedge clk) begin
    if (state_q == USER_IDLE && (rrq_i || wrq_i)) begin
      cmd_wdata_o.is_read <= rrq_i;
      cmd_wdata_o.addr    <= adr_i;
      tx_wdata_o          <= tx_dat_i;
    end
    if (state_q == USER_WAIT_READ && !rx_rempty_i) begin
      rx_dat_o <= rx_rdata_i;
    end
  end

endmodule : hbus_user_ctrl

`default_nettype wire

//--- hyperbus_fifo/hbus_sync_fifo.sv
// HyperBus synchronous FIFO: first-word-fall-through queue with a combinational head
`default_nettype none

`include "hbus_bridge_config.svh"

module hbus_sync_fifo #(
  parameter int unsigned DATA_W = 32
) (
  input  wire logic              clk,
  input  wire logic              hbus_rst,
  input  wire logic              winc_i,
  input  wire logic [DATA_W-1:0] wdata_i,
  output logic                   wfull_o,
  input  wire logic              rinc_i,
  output logic      [DATA_W-1:0] rdata_o,
  output logic                   rempty_o
);

  localparam int unsigned ASIZE = `HBUS_FIFO_ASIZE;
  localparam int unsigned DEPTH = 1 << ASIZE;

  logic [DATA_W-1:0] mem [DEPTH];

  // Pointers carry one wrap bit above the index
  logic [ASIZE:0] wptr_q;
  logic [ASIZE:0] rptr_q;

  logic do_push;
  logic do_pop;

  assign rempty_o = (wptr_q == rptr_q);
  assign wfull_o  = (wptr_q[ASIZE] != rptr_q[ASIZE]) &&
                    (wptr_q[ASIZE-1:0] == rptr_q[ASIZE-1:0]);

  // Pushes into a full queue and pops from an empty one are dropped
  assign do_push = winc_i && !wfull_o;
  assign do_pop  = rinc_i && !rempty_o;

  // Head word falls through
  assign rdata_o = mem[rptr_q[ASIZE-1:0]];

  always_ff @(posedge clk or posedge hbus_rst) begin
    if (hbus_rst) begin
      wptr_q <= '0;
      rptr_q <= '0;
    end else begin
      if (do_push) begin
        wptr_q <= wptr_q + 1'b1;
      end
      if (do_pop) begin
        rptr_q <= rptr_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wptr_q[ASIZE-1:0]] <= wdata_i;
    end
  end

endmodule : hbus_sync_fifo

`default_nettype wire

//--- common/hbus_cmd_pkg.sv
// HyperBus command package: queued command format, user word and controller states
`default_nettype none

`include "hbus_bridge_config.svh"

package hbus_cmd_pkg;

  import hbus_native_pkg::*;

  // One user data word
  typedef logic [`HBUS_FIFO_DATA_W-1:0] user_word_t;

  // Command queue entry, read flag on top of the address
  typedef struct packed {
    logic       is_read;
    hbus_addr_t addr;
  } hbus_cmd_t;

  // User side FSM
  typedef enum logic [1:0] {
    USER_IDLE,
    USER_WAIT_READ,
    USER_WAIT_WRITE
  } user_state_e;

  // Bus side FSM
  typedef enum logic [1:0] {
    XFER_IDLE,
    XFER_READ,
    XFER_WRITE
  } xfer_state_e;

endpackage : hbus_cmd_pkg

`default_nettype wire

//--- common/hbus_native_pkg.sv
// HyperBus native package: types of the memory-side bus beat, address and beat count
`default_nettype none

`include "hbus_bridge_config.svh"

package hbus_native_pkg;

  // One 16-bit beat on the memory data bus
  typedef logic [`HBUS_DATA_W-1:0] hbus_beat_t;

  // Memory address as driven on the bus
  typedef logic [`HBUS_ADDR_W-1:0] hbus_addr_t;

  // Beat down-counter, must be able to hold HBUS_BEATS itself
  typedef logic [$clog2(`HBUS_BEATS + 1)-1:0] hbus_beat_cnt_t;

endpackage : hbus_native_pkg

`default_nettype wire

//--- common/hbus_bridge_config.svh
// HyperBus bridge configuration: word, beat and address widths and queue depth
`ifndef HBUS_BRIDGE_CONFIG_SVH
`define HBUS_BRIDGE_CONFIG_SVH

// User side word width
`define HBUS_FIFO_DATA_W 32

// Width of one beat on the memory bus
`define HBUS_DATA_W 16

// Memory address width, shared by the user port and the bus
`define HBUS_ADDR_W 32

// Log2 of the queue depth
`define HBUS_FIFO_ASIZE 3

// Bus beats per user word
`define HBUS_BEATS (`HBUS_FIFO_DATA_W / `HBUS_DATA_W)

// One outstanding request never needs more than a single entry,
// the extra depth only leaves headroom

`endif
